//--- sine_quarter.mem
// quarter-wave sine magnitude, 12-bit hex, entry i = round(4095 * sin((i + 0.5) * pi / 64))
064
12D
1F5
2BC
381
444
505
5C2
67B
731
7E2
88F
936
9D7
A73
B08
B96
C1D
C9C
D14
D84
DEB
E4A
EA0
EED
F30
F6B
F9C
FC3
FE0
FF4
FFE

//--- project.f
opl_op_pkg.sv
sample_clk_div.sv
phase_gen.sv
env_gen.sv
op_out.sv
fm_operator.sv
fm_operator_properties.sv
fm_operator_tb.sv

//--- Bender.yml
package:
  name: fm_operator

sources:
  - opl_op_pkg.sv
  - sample_clk_div.sv
  - phase_gen.sv
  - env_gen.sv
  - op_out.sv
  - fm_operator.sv
  - target: test
    files:
      - fm_operator_properties.sv
      - fm_operator_tb.sv

//--- fm_operator_tb.sv
/*
 * Testbench for the FM operator. Drives random register values from an xorshift
 * source on falling edges and checks every output sample against a behavioral model.
 */
module fm_operator_tb;

    import opl_op_pkg::*;

    localparam int SAMPLE_DIV   = 8;           // clocks per sample in this run
    localparam int CLK_PERIOD   = 20;
    localparam int TONE_COUNT   = 4;
    localparam int TONE_LEN     = 24;          // samples per tone
    localparam int NOTE_COUNT   = 6;
    localparam int NOTE_ON_MAX  = 39;
    localparam int NOTE_OFF_LEN = 40;
    localparam int TL_LEN       = 48;
    localparam int MOD_LEN      = 64;
    localparam int RELEASE_MAX  = 140;         // rr >= 4 reaches silence in 128
    localparam int OFF_HOLD_LEN = 16;
    localparam int TOTAL_SAMPLES = 1 + TONE_COUNT * TONE_LEN
        + NOTE_COUNT * (NOTE_ON_MAX + NOTE_OFF_LEN) + TL_LEN + MOD_LEN
        + RELEASE_MAX + OFF_HOLD_LEN + 1;
    localparam longint TIMEOUT = longint'(TOTAL_SAMPLES) * SAMPLE_DIV * CLK_PERIOD * 2;
    localparam real PI = 3.14159265358979;

    logic                        clk;
    logic                        rst_n;
    logic [FNUM_WIDTH-1:0]       fnum;
    logic [BLOCK_WIDTH-1:0]      block;
    logic [MULT_WIDTH-1:0]       mult;
    logic [RATE_WIDTH-1:0]       ar;
    logic [RATE_WIDTH-1:0]       dr;
    logic [RATE_WIDTH-1:0]       sl;
    logic [RATE_WIDTH-1:0]       rr;
    logic [TL_WIDTH-1:0]         tl;
    logic                        egt;
    logic                        kon;
    logic [PHASE_WIDTH-1:0]      modulation;
    logic signed [OUT_WIDTH-1:0] out;
    logic                        sample_valid;

    // reference model state
    int         sine_tab [SINE_DEPTH];
    int         m_acc;                         // phase accumulator
    int         m_level;                       // linear envelope level
    env_state_t m_state;
    logic       m_kon_prev;
    int         exp_out;                       // expected sample
    logic [31:0] rng;                          // xorshift state

    fm_operator #(
        .SAMPLE_DIV(SAMPLE_DIV)
    ) i_fm_operator (
        .clk          (clk),
        .rst_n        (rst_n),
        .fnum         (fnum),
        .block        (block),
        .mult         (mult),
        .ar           (ar),
        .dr           (dr),
        .sl           (sl),
        .rr           (rr),
        .tl           (tl),
        .egt          (egt),
        .kon          (kon),
        .modulation   (modulation),
        .out          (out),
        .sample_valid (sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // end the run if the sample stream stalls
    initial begin
        #(TIMEOUT);
        $display("timeout: the sample stream did not finish in the expected run time");
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped by watchdog");
    end

    function automatic int rand_range(input int lo, input int hi);
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return lo + int'(rng % 32'(hi - lo + 1));
    endfunction

    function automatic int min_int(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    task automatic fail_value(input string name, input int exp, input int act);
        $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        $display("STATUS: FAIL");
        $fatal(1, "stopping at first mismatch");
    endtask

    // one sample of phase, envelope and output rules on the driven inputs
    task automatic model_step();
        int m_factor;
        int inc;
        int phase;
        int target;
        int atten;
        int quad;
        int idx;
        int mag;
        m_factor = (int'(mult) == 0) ? 1 : 2 * int'(mult);
        inc      = ((int'(fnum) << int'(block)) * m_factor) / 2;
        m_acc    = (m_acc + inc) % (1 << ACC_WIDTH);
        phase    = ((m_acc >> (ACC_WIDTH - PHASE_WIDTH)) + int'(modulation))
                   % (1 << PHASE_WIDTH);
        target   = min_int(int'(sl) * 32, 511);     // sustain level
        if (kon && !m_kon_prev) begin
            m_state = ENV_ATTACK;
        end else if (!kon && m_kon_prev) begin
            m_state = ENV_RELEASE;
        end else begin
            case (m_state)
                ENV_ATTACK: begin
                    m_level = (m_level > 8 * int'(ar)) ? m_level - 8 * int'(ar) : 0;
                    if (m_level == 0) m_state = ENV_DECAY;
                end
                ENV_DECAY: begin
                    m_level = min_int(m_level + int'(dr), target);
                    if (m_level == target) m_state = ENV_SUSTAIN;
                end
                ENV_SUSTAIN: begin
                    if (!egt) begin                     // no hold so it keeps fading
                        m_level = min_int(m_level + int'(rr), 511);
                        if (m_level == 511) m_state = ENV_OFF;
                    end
                end
                ENV_RELEASE: begin
                    m_level = min_int(m_level + int'(rr), 511);
                    if (m_level == 511) m_state = ENV_OFF;
                end
                default: m_level = 511;
            endcase
        end
        m_kon_prev = kon;
        atten   = min_int(m_level + 4 * int'(tl), 511);
        quad    = phase >> 8;
        idx     = (phase >> 3) % 32;
        mag     = (sine_tab[(quad % 2 == 1) ? 31 - idx : idx] * (512 - atten)) >> 9;
        exp_out = (quad >= 2) ? -mag : mag;         // lower half wave
    endtask

    // step the model and compare it with the next DUT sample
    task automatic run_sample(input string name);
        model_step();
        do @(negedge clk); while (!sample_valid);
        assert (out == exp_out) else fail_value(name, exp_out, int'(out));
        @(negedge clk);
    endtask

    task automatic check_reset();
        int cycles;
        cycles = 0;
        model_step();
        do begin
            @(negedge clk);
            cycles++;
            if (!sample_valid) begin
                assert (out == 0) else fail_value("reset", 0, int'(out));
            end
        end while (!sample_valid);
        assert (cycles == SAMPLE_DIV + 2)
            else fail_value("reset_latency", SAMPLE_DIV + 2, cycles);
        assert (out == exp_out) else fail_value("reset", exp_out, int'(out));
        @(negedge clk);
    endtask

    initial begin
        int i;
        int j;
        int n_on;
        rng        = 32'd30257;
        rst_n      = 1'b0;
        fnum       = '0;
        block      = '0;
        mult       = '0;
        ar         = '0;
        dr         = '0;
        sl         = '0;
        rr         = '0;
        tl         = '0;
        egt        = 1'b0;
        kon        = 1'b0;
        modulation = '0;
        m_acc      = 0;
        m_level    = 511;
        m_state    = ENV_OFF;
        m_kon_prev = 1'b0;
        for (i = 0; i < SINE_DEPTH; i++) begin
            sine_tab[i] = $rtoi(4095.0 * $sin((i + 0.5) * PI / 64.0) + 0.5);
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        check_reset();

        // full-volume tones with sustain held at level 0
        kon = 1'b1;
        ar  = 4'd15;
        sl  = '0;
        egt = 1'b1;
        for (i = 0; i < TONE_COUNT; i++) begin
            fnum  = FNUM_WIDTH'(rand_range(0, 1023));
            block = BLOCK_WIDTH'(rand_range(0, 7));
            for (j = 0; j < TONE_LEN; j++) run_sample("tone_full");
        end

        // random notes through every envelope state
        for (i = 0; i < NOTE_COUNT; i++) begin
            ar    = RATE_WIDTH'(rand_range(1, 15));
            dr    = RATE_WIDTH'(rand_range(0, 15));
            sl    = RATE_WIDTH'(rand_range(0, 15));
            rr    = RATE_WIDTH'(rand_range(0, 15));
            egt   = rand_range(0, 1) == 1;
            fnum  = FNUM_WIDTH'(rand_range(0, 1023));
            block = BLOCK_WIDTH'(rand_range(0, 7));
            mult  = MULT_WIDTH'(rand_range(0, 15));
            kon   = 1'b1;
            n_on  = rand_range(8, NOTE_ON_MAX);
            for (j = 0; j < n_on; j++) run_sample("adsr");
            kon = 1'b0;
            for (j = 0; j < NOTE_OFF_LEN; j++) run_sample("adsr");
        end

        // total level swept while sustaining
        kon = 1'b1;
        ar  = 4'd15;
        dr  = 4'd15;
        sl  = RATE_WIDTH'(rand_range(0, 7));
        egt = 1'b1;
        for (j = 0; j < TL_LEN; j++) begin
            tl = TL_WIDTH'(rand_range(0, 63));
            run_sample("total_level");
        end

        // modulation offsets reach all four quadrants
        tl = '0;
        for (j = 0; j < MOD_LEN; j++) begin
            modulation = PHASE_WIDTH'(rand_range(0, 1023));
            fnum       = FNUM_WIDTH'(rand_range(0, 1023));
            block      = BLOCK_WIDTH'(rand_range(0, 7));
            mult       = MULT_WIDTH'(rand_range(0, 15));
            run_sample("modulation");
        end

        // key off then fade to silence and stay silent
        fnum = '0;                                  // phase stands still
        // park the phase on entry 0 so full attenuation gives exactly 0
        modulation = PHASE_WIDTH'((1 << PHASE_WIDTH) - (m_acc >> (ACC_WIDTH - PHASE_WIDTH)));
        rr  = RATE_WIDTH'(rand_range(4, 15));
        kon = 1'b0;
        j   = 0;
        do begin
            run_sample("release_off");
            j++;
        end while (m_state != ENV_OFF && j < RELEASE_MAX);
        assert (out == 0) else fail_value("release_off", 0, int'(out));
        for (j = 0; j < OFF_HOLD_LEN; j++) begin
            run_sample("release_off");
            assert (out == 0) else fail_value("release_off", 0, int'(out));
        end
        kon = 1'b1;
        run_sample("release_off");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- fm_operator_properties.sv
/*
 * Concurrent checks on the FM operator sample strobes, output hold and
 * envelope silence. Bound into the top level.
 */
module fm_operator_properties (
    input logic                                      clk,
    input logic                                      rst_n,
    input logic                                      sample_en,
    input logic                                      sample_valid,
    input logic signed [opl_op_pkg::OUT_WIDTH-1:0]   out,
    input logic        [opl_op_pkg::ATTEN_WIDTH-1:0] atten,
    input opl_op_pkg::env_state_t                    env_state
);

    import opl_op_pkg::*;

    valid_two_after_en: assert property (@(posedge clk) disable iff (!rst_n)
        sample_en |-> ##2 sample_valid)
        else $error("sample_valid did not follow sample_en by two cycles");

    valid_only_from_en: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |-> $past(sample_en, 2))
        else $error("sample_valid without sample_en two cycles earlier");

    off_is_silent: assert property (@(posedge clk) disable iff (!rst_n)
        env_state == ENV_OFF |-> atten == ATTEN_MAX)
        else $error("envelope off but attenuation below maximum");

    out_holds: assert property (@(posedge clk) disable iff (!rst_n)
        !sample_valid |-> $stable(out))
        else $error("out changed outside a sample_valid cycle");

    reset_clears_valid: assert property (@(posedge clk)
        !rst_n |=> !sample_valid)
        else $error("sample_valid high right after reset");

endmodule

bind fm_operator fm_operator_properties i_fm_operator_properties (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_en    (sample_en),
    .sample_valid (sample_valid),
    .out          (out),
    .atten        (atten),
    .env_state    (i_env_gen.state)
);

//--- fm_operator.sv
/*
 * FM operator top level. Sample divider drives the phase and envelope
 * generators in parallel; the output stage combines them into a signed stream.
 */
module fm_operator #(
    parameter int SAMPLE_DIV = 64                          // clocks per output sample
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic        [opl_op_pkg::FNUM_WIDTH-1:0]  fnum,
    input  logic        [opl_op_pkg::BLOCK_WIDTH-1:0] block,
    input  logic        [opl_op_pkg::MULT_WIDTH-1:0]  mult,
    input  logic        [opl_op_pkg::RATE_WIDTH-1:0]  ar,
    input  logic        [opl_op_pkg::RATE_WIDTH-1:0]  dr,
    input  logic        [opl_op_pkg::RATE_WIDTH-1:0]  sl,
    input  logic        [opl_op_pkg::RATE_WIDTH-1:0]  rr,
    input  logic        [opl_op_pkg::TL_WIDTH-1:0]    tl,
    input  logic                                      egt,
    input  logic                                      kon,
    input  logic        [opl_op_pkg::PHASE_WIDTH-1:0] modulation,
    output logic signed [opl_op_pkg::OUT_WIDTH-1:0]   out,
    output logic                                      sample_valid
);

    import opl_op_pkg::*;

    logic                   sample_en;     // one cycle per sample
    logic [PHASE_WIDTH-1:0] phase_idx;
    logic [ATTEN_WIDTH-1:0] atten;

    sample_clk_div #(
        .SAMPLE_DIV(SAMPLE_DIV)
    ) i_sample_clk_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en)
    );

    phase_gen i_phase_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample_en  (sample_en),
        .fnum       (fnum),
        .block      (block),
        .mult       (mult),
        .modulation (modulation),
        .phase_idx  (phase_idx)
    );

    env_gen i_env_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en),
        .kon       (kon),
        .egt       (egt),
        .ar        (ar),
        .dr        (dr),
        .sl        (sl),
        .rr        (rr),
        .tl        (tl),
        .atten     (atten)
    );

    op_out i_op_out (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_en    (sample_en),
        .phase_idx    (phase_idx),
        .atten        (atten),
        .out          (out),
        .sample_valid (sample_valid)
    );

endmodule

//--- op_out.sv
/*
 * Output stage. Quarter-wave sine lookup with quadrant mirroring, linear
 * attenuation scaling and a registered signed sample one cycle after sample_en.
 */
module op_out (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      sample_en,
    input  logic        [opl_op_pkg::PHASE_WIDTH-1:0] phase_idx,
    input  logic        [opl_op_pkg::ATTEN_WIDTH-1:0] atten,
    output logic signed [opl_op_pkg::OUT_WIDTH-1:0]   out,
    output logic                                      sample_valid
);

    import opl_op_pkg::*;

    localparam int GAIN_WIDTH  = ATTEN_WIDTH + 1;          // 512 - atten, up to 512
    localparam int SCALE_WIDTH = SINE_WIDTH + GAIN_WIDTH;

    logic [SINE_WIDTH-1:0]      sine_rom [SINE_DEPTH];     // quarter-wave magnitude
    logic                       calc_en;                   // sample_en delayed one cycle
    logic [1:0]                 quadrant;
    logic [SINE_ADDR_WIDTH-1:0] index;
    logic [SINE_ADDR_WIDTH-1:0] rom_addr;
    logic [SINE_WIDTH-1:0]      sine_mag;
    logic [GAIN_WIDTH-1:0]      gain;
    logic [SCALE_WIDTH-1:0]     scaled;
    logic [OUT_WIDTH-1:0]       mag;                       // unsigned, after >> 9
    logic signed [OUT_WIDTH-1:0] sample;

    initial $readmemh(SINE_FILE, sine_rom);

    always_comb begin
        quadrant = phase_idx[PHASE_WIDTH-1 -: 2];
        index    = phase_idx[PHASE_WIDTH-3 -: SINE_ADDR_WIDTH];
        rom_addr = quadrant[0] ? ~index : index;           // 31 - index on falling quarters
        sine_mag = sine_rom[rom_addr];
        gain     = GAIN_WIDTH'(2**ATTEN_WIDTH) - GAIN_WIDTH'(atten);
        scaled   = SCALE_WIDTH'(sine_mag) * SCALE_WIDTH'(gain);
        mag      = OUT_WIDTH'(scaled >> ATTEN_WIDTH);
        sample   = quadrant[1] ? -$signed(mag) : $signed(mag); // negative half wave
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            calc_en      <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            calc_en      <= sample_en;
            sample_valid <= calc_en;                       // one-cycle strobe with out
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out <= '0;
        end else if (calc_en) begin
            out <= sample;                                 // holds between samples
        end
    end

endmodule

//--- env_gen.sv
/*
 * Envelope generator. ADSR state machine stepped once per sample from kon edges,
 * with a linear level; atten adds total level and saturates at silence.
 */
module env_gen (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               sample_en,
    input  logic                               kon,
    input  logic                               egt,
    input  logic [opl_op_pkg::RATE_WIDTH-1:0]  ar,
    input  logic [opl_op_pkg::RATE_WIDTH-1:0]  dr,
    input  logic [opl_op_pkg::RATE_WIDTH-1:0]  sl,
    input  logic [opl_op_pkg::RATE_WIDTH-1:0]  rr,
    input  logic [opl_op_pkg::TL_WIDTH-1:0]    tl,
    output logic [opl_op_pkg::ATTEN_WIDTH-1:0] atten
);

    import opl_op_pkg::*;

    env_state_t             state;
    env_state_t             state_next;
    logic [ATTEN_WIDTH-1:0] level;          // linear attenuation, 0 is loudest
    logic [ATTEN_WIDTH-1:0] level_next;
    logic                   kon_prev;       // kon at previous sample
    logic [ATTEN_WIDTH-1:0] atk_step;       // 8 * ar
    logic [ATTEN_WIDTH-1:0] sus_target;     // min(sl * 32, 511)
    logic [RATE_WIDTH+4:0]  sl_scaled;
    logic [ATTEN_WIDTH-1:0] tl_scaled;      // 4 * tl

    // add with saturation at cap
    function automatic logic [ATTEN_WIDTH-1:0] sat_add(
        input logic [ATTEN_WIDTH-1:0] base,
        input logic [ATTEN_WIDTH-1:0] step,
        input logic [ATTEN_WIDTH-1:0] cap
    );
        logic [ATTEN_WIDTH:0] sum;
        sum = {1'b0, base} + {1'b0, step};
        return (sum >= {1'b0, cap}) ? cap : sum[ATTEN_WIDTH-1:0];
    endfunction

    assign atk_step   = ATTEN_WIDTH'({ar, 3'b000});
    assign sl_scaled  = {sl, 5'b00000};
    assign sus_target = (sl_scaled > ATTEN_MAX) ? ATTEN_MAX : ATTEN_WIDTH'(sl_scaled);
    assign tl_scaled  = ATTEN_WIDTH'({tl, 2'b00});

    always_comb begin
        state_next = state;
        level_next = level;
        if (kon && !kon_prev) begin
            state_next = ENV_ATTACK;        // key on, level kept
        end else if (!kon && kon_prev) begin
            state_next = ENV_RELEASE;       // key off, level kept
        end else begin
            case (state)
                ENV_ATTACK: begin
                    if (level <= atk_step) begin
                        level_next = '0;
                        state_next = ENV_DECAY;
                    end else begin
                        level_next = level - atk_step;
                    end
                end
                ENV_DECAY: begin
                    level_next = sat_add(level, ATTEN_WIDTH'(dr), sus_target);
                    if (level_next == sus_target) state_next = ENV_SUSTAIN;
                end
                ENV_SUSTAIN: begin
                    if (!egt) begin         // percussive, keeps fading
                        level_next = sat_add(level, ATTEN_WIDTH'(rr), ATTEN_MAX);
                        if (level_next == ATTEN_MAX) state_next = ENV_OFF;
                    end
                end
                ENV_RELEASE: begin
                    level_next = sat_add(level, ATTEN_WIDTH'(rr), ATTEN_MAX);
                    if (level_next == ATTEN_MAX) state_next = ENV_OFF;
                end
                default: level_next = ATTEN_MAX; // ENV_OFF
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ENV_OFF;
            level    <= ATTEN_MAX;
            kon_prev <= 1'b0;
            atten    <= ATTEN_MAX;
        end else if (sample_en) begin
            state    <= state_next;
            level    <= level_next;
            kon_prev <= kon;
            atten    <= sat_add(level_next, tl_scaled, ATTEN_MAX); // total level on top
        end
    end

endmodule

//--- phase_gen.sv
/*
 * Phase generator. Accumulates (fnum << block) * M / 2 per sample and outputs
 * the top accumulator bits plus the external modulation as the table phase.
 */
module phase_gen (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               sample_en,
    input  logic [opl_op_pkg::FNUM_WIDTH-1:0]  fnum,
    input  logic [opl_op_pkg::BLOCK_WIDTH-1:0] block,
    input  logic [opl_op_pkg::MULT_WIDTH-1:0]  mult,
    input  logic [opl_op_pkg::PHASE_WIDTH-1:0] modulation,
    output logic [opl_op_pkg::PHASE_WIDTH-1:0] phase_idx
);

    import opl_op_pkg::*;

    localparam int SHIFT_WIDTH = FNUM_WIDTH + 2**BLOCK_WIDTH - 1; // fnum at max block
    localparam int M_WIDTH     = MULT_WIDTH + 1;                  // twice mult
    localparam int PROD_WIDTH  = SHIFT_WIDTH + M_WIDTH;

    logic [ACC_WIDTH-1:0]   acc;            // phase accumulator
    logic [ACC_WIDTH-1:0]   acc_next;
    logic [SHIFT_WIDTH-1:0] fnum_shifted;   // fnum << block
    logic [M_WIDTH-1:0]     mult_factor;    // M: 1 for code 0, else 2*mult
    logic [PROD_WIDTH-1:0]  product;
    logic [ACC_WIDTH-1:0]   inc;            // product / 2, mod 2^20

    always_comb begin
        fnum_shifted = SHIFT_WIDTH'(fnum) << block;
        if (mult == '0) begin
            mult_factor = M_WIDTH'(1);      // half-rate multiplier
        end else begin
            mult_factor = {mult, 1'b0};
        end
        product  = PROD_WIDTH'(fnum_shifted) * PROD_WIDTH'(mult_factor);
        inc      = product[ACC_WIDTH:1];    // divide by 2, drop wrap bits
        acc_next = acc + inc;               // wraps naturally
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc       <= '0;
            phase_idx <= '0;
        end else if (sample_en) begin
            acc       <= acc_next;
            // top bits of the new phase, offset by modulation, wrap to 10 bits
            phase_idx <= acc_next[ACC_WIDTH-1 -: PHASE_WIDTH] + modulation;
        end
    end

endmodule

//--- sample_clk_div.sv
/*
 * Clock-enable divider. Emits a one-cycle sample_en every SAMPLE_DIV clocks,
 * first pulse SAMPLE_DIV cycles after reset is released.
 */
module sample_clk_div #(
    parameter int SAMPLE_DIV = 64           // clocks per sample, at least 3
) (
    input  logic clk,
    input  logic rst_n,
    output logic sample_en
);

    localparam int CNT_WIDTH = $clog2(SAMPLE_DIV);

    logic [CNT_WIDTH-1:0] cnt;              // down-counter

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= CNT_WIDTH'(SAMPLE_DIV - 1);
            sample_en <= 1'b0;
        end else if (cnt == '0) begin
            cnt       <= CNT_WIDTH'(SAMPLE_DIV - 1); // reload
            sample_en <= 1'b1;
        end else begin
            cnt       <= cnt - 1'b1;
            sample_en <= 1'b0;
        end
    end

endmodule

//--- opl_op_pkg.sv
/*
 * Shared widths, envelope states and sine-table constants for the FM operator.
 * Modules import it inside the body and use scoped names in their port lists.
 */
package opl_op_pkg;

    // register field widths
    parameter int FNUM_WIDTH  = 10;         // frequency number
    parameter int BLOCK_WIDTH = 3;          // octave block
    parameter int MULT_WIDTH  = 4;          // multiplier code
    parameter int RATE_WIDTH  = 4;          // ar, dr, sl, rr
    parameter int TL_WIDTH    = 6;          // total level

    // phase path
    parameter int ACC_WIDTH   = 20;         // phase accumulator, wraps at 2^20
    parameter int PHASE_WIDTH = 10;         // table phase index, also modulation width

    // envelope path
    parameter int ATTEN_WIDTH = 9;          // 0 is full volume
    parameter logic [ATTEN_WIDTH-1:0] ATTEN_MAX = {ATTEN_WIDTH{1'b1}}; // silence, 511

    // quarter-wave sine table
    parameter int    SINE_WIDTH      = 12;  // magnitude bits
    parameter int    SINE_DEPTH      = 32;  // entries per quarter wave
    parameter int    SINE_ADDR_WIDTH = $clog2(SINE_DEPTH);
    parameter string SINE_FILE       = "sine_quarter.mem"; // hex, one entry per line

    // output sample
    parameter int OUT_WIDTH = 13;           // signed, sine magnitude plus sign

    // envelope generator states
    typedef enum logic [2:0] {
        ENV_ATTACK,                         // level falling toward 0
        ENV_DECAY,                          // rising toward sustain target
        ENV_SUSTAIN,                        // hold or slow rise, per egt
        ENV_RELEASE,                        // key released, rising to silence
        ENV_OFF                             // silent, level pinned at max
    } env_state_t;

endpackage
